/* vlog.f */
+incdir+design
design/me_pkg.sv
design/mont_mult.sv
design/r2_gen.sv
design/me_operands.sv
design/me_ctrl.sv
design/me_top.sv
tests/me_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := me_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/me_tb.sv */
`include "me_config.svh"

module me_tb;

    localparam int W             = `ME_WIDTH;
    localparam int CYCLES_PER_OP = 3000;

    logic         clk;
    logic         rst_n;
    logic         start;
    logic [W-1:0] x;
    logic [W-1:0] y;
    logic [W-1:0] m;
    logic         busy;
    logic         valid;
    logic [W-1:0] result;

    logic [31:0]  lfsr_state;
    int           errors     = 0;
    int           checks     = 0;
    int           ops_issued = 0;
    int           cycle_cnt  = 0;

    me_top u_me_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .x      (x),
        .y      (y),
        .m      (m),
        .busy   (busy),
        .valid  (valid),
        .result (result)
    );

    always #5 clk = ~clk;

    // watchdog limit grows with every start issued
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLES_PER_OP * ops_issued + 100) begin
            $display("timeout after %0d cycles, valid did not arrive", cycle_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------
    // reference model and lfsr
    // ------------------------------

    // left-to-right square-and-multiply on plain integers
    function automatic logic [W-1:0] model_modexp(
        input logic [W-1:0] base,
        input logic [W-1:0] expo,
        input logic [W-1:0] modulus
    );
        logic [63:0] acc;
        logic [63:0] b;
        acc = 64'd1 % modulus;
        b   = base % modulus;
        for (int i = W - 1; i >= 0; i--) begin
            acc = (acc * acc) % modulus;
            if (expo[i]) begin
                acc = (acc * b) % modulus;
            end
        end
        return acc[W-1:0];
    endfunction

    // galois lfsr stepped once per bit taken
    function automatic logic [W-1:0] lfsr_bits(input int n);
        logic [W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[W-2:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // ------------------------------
    // drive and wait helpers
    // ------------------------------

    task automatic issue_start(input logic [W-1:0] xv, input logic [W-1:0] yv,
                               input logic [W-1:0] mv);
        @(posedge clk);
        #1;
        x     = xv;
        y     = yv;
        m     = mv;
        start = 1'b1;
        ops_issued++;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    // samples one unit after each edge and flags busy dropping early
    task automatic wait_valid(output logic dropped);
        dropped = 1'b0;
        while (!valid) begin
            if (!busy) begin
                dropped = 1'b1;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_case(input logic [W-1:0] xv, input logic [W-1:0] yv,
                            input logic [W-1:0] mv, input logic [W-1:0] expected);
        logic dropped;
        issue_start(xv, yv, mv);
        wait_valid(dropped);
        checks++;
        if (result !== expected) begin
            $display("Fail at %0t: result got %h expected %h (x=%h y=%h m=%h)",
                     $time, result, expected, xv, yv, mv);
            errors++;
        end
        if (dropped) begin
            $display("error at %0t: busy went low before valid", $time);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-18s %s", name, (errors == errs_before) ? "ok" : "failed");
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------

    task automatic reset_values();
        int e0;
        e0 = errors;
        checks++;
        if (busy !== 1'b0) begin
            $display("Fail at %0t: busy got %b expected %b", $time, busy, 1'b0);
            errors++;
        end
        if (valid !== 1'b0) begin
            $display("Fail at %0t: valid got %b expected %b", $time, valid, 1'b0);
            errors++;
        end
        if (result !== '0) begin
            $display("Fail at %0t: result got %h expected %h", $time, result, 32'h0);
            errors++;
        end
        report_test("reset_values", e0);
    endtask

    task automatic fixed_cases();
        int e0;
        e0 = errors;
        run_case(3, 5, 7, model_modexp(3, 5, 7));
        run_case(2, 10, 1001, model_modexp(2, 10, 1001));
        run_case(32'hDEADBEEF, 32'hFFFFFFFF, 32'hFFFFFFFB,
                 model_modexp(32'hDEADBEEF, 32'hFFFFFFFF, 32'hFFFFFFFB));
        report_test("fixed_cases", e0);
    endtask

    task automatic edge_exponents();
        int e0;
        e0 = errors;
        run_case(12345, 0, 1001, 1);
        run_case(32'hDEADBEEF, 1, 1000003, 32'hDEADBEEF % 1000003);
        run_case(0, 7, 97, 0);
        report_test("edge_exponents", e0);
    endtask

    task automatic random_triples();
        int           e0;
        logic [W-1:0] xv;
        logic [W-1:0] yv;
        logic [W-1:0] mv;
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            xv = lfsr_bits(W);
            yv = lfsr_bits(W);
            mv = lfsr_bits(W) | 1;
            if (mv < 3) begin
                mv = 3;
            end
            run_case(xv, yv, mv, model_modexp(xv, yv, mv));
        end
        report_test("random", e0);
    endtask

    task automatic start_while_busy();
        int   e0;
        logic dropped;
        logic early_drop;
        e0 = errors;
        early_drop = 1'b0;
        issue_start(32'h1234_5677, 32'h8000_0011, 32'h7FFF_FFED);
        repeat (40) begin
            @(posedge clk);
            #1;
            if (!busy) begin
                early_drop = 1'b1;
            end
        end
        // second start mid-run must be ignored
        x     = 32'h0BAD_CAFE;
        y     = 32'h0000_0003;
        m     = 32'h0000_0065;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait_valid(dropped);
        checks++;
        if (result !== model_modexp(32'h1234_5677, 32'h8000_0011, 32'h7FFF_FFED)) begin
            $display("Fail at %0t: result got %h expected %h", $time, result,
                     model_modexp(32'h1234_5677, 32'h8000_0011, 32'h7FFF_FFED));
            errors++;
        end
        if (dropped || early_drop) begin
            $display("error at %0t: busy went low before valid", $time);
            errors++;
        end
        report_test("start_while_busy", e0);
    endtask

    task automatic hold_after_valid();
        int           e0;
        logic [W-1:0] held;
        e0 = errors;
        run_case(77, 13, 211, model_modexp(77, 13, 211));
        held = result;
        repeat (20) begin
            @(posedge clk);
            #1;
            if (result !== held) begin
                $display("Fail at %0t: result got %h expected %h", $time, result, held);
                errors++;
            end
            if (busy !== 1'b0) begin
                $display("Fail at %0t: busy got %b expected %b", $time, busy, 1'b0);
                errors++;
            end
            if (valid !== 1'b0) begin
                $display("Fail at %0t: valid got %b expected %b", $time, valid, 1'b0);
                errors++;
            end
        end
        run_case(5, 117, 1009, model_modexp(5, 117, 1009));
        report_test("hold_after_valid", e0);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        x          = '0;
        y          = '0;
        m          = '0;
        lfsr_state = 32'h2f14_236a;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_values();
        fixed_cases();
        edge_exponents();
        random_triples();
        start_while_busy();
        hold_after_valid();

        $display("summary: %0d checks, %0d errors, %0d starts", checks, errors, ops_issued);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* design/me_top.sv */
`include "me_config.svh"

module me_top
    import me_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [`ME_WIDTH-1:0] x,
    input  logic [`ME_WIDTH-1:0] y,
    input  logic [`ME_WIDTH-1:0] m,
    output logic                 busy,
    output logic                 valid,
    output logic [`ME_WIDTH-1:0] result
);

    logic                 load;
    logic                 r2_start;
    logic                 r2_done;
    logic                 mm_start;
    logic                 mm_done;
    logic                 prod_wr;
    mm_op_t               mm_op;
    logic [`ME_WIDTH-1:0] m_q;
    logic [`ME_WIDTH-1:0] rou;
    logic [`ME_WIDTH-1:0] mm_a;
    logic [`ME_WIDTH-1:0] mm_b;
    logic [`ME_WIDTH-1:0] product;

    // square-and-multiply sequencer
    me_ctrl u_me_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .y        (y),
        .r2_done  (r2_done),
        .mm_done  (mm_done),
        .busy     (busy),
        .valid    (valid),
        .load     (load),
        .r2_start (r2_start),
        .mm_start (mm_start),
        .mm_op    (mm_op),
        .prod_wr  (prod_wr)
    );

    me_operands u_me_operands (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .x       (x),
        .m       (m),
        .rou     (rou),
        .mm_op   (mm_op),
        .prod_wr (prod_wr),
        .product (product),
        .m_q     (m_q),
        .mm_a    (mm_a),
        .mm_b    (mm_b),
        .result  (result)
    );

    mont_mult u_mont_mult (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mm_start),
        .a       (mm_a),
        .b       (mm_b),
        .m       (m_q),
        .done    (mm_done),
        .product (product)
    );

    // rou from the captured modulus
    r2_gen u_r2_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .start (r2_start),
        .m     (m_q),
        .done  (r2_done),
        .rou   (rou)
    );

endmodule

/* design/me_ctrl.sv */
`include "me_config.svh"

module me_ctrl
    import me_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [`ME_WIDTH-1:0] y,
    input  logic                 r2_done,
    input  logic                 mm_done,
    output logic                 busy,
    output logic                 valid,
    output logic                 load,
    output logic                 r2_start,
    output logic                 mm_start,
    output mm_op_t               mm_op,
    output logic                 prod_wr
);

    // square counter values, checked before and after the increment
    localparam logic [`ME_BIT_CNT_W-1:0] LAST_SQ = `ME_EXP_W - 1;
    localparam logic [`ME_BIT_CNT_W-1:0] ALL_SQ  = `ME_EXP_W;

    me_state_t                state;
    logic [`ME_EXP_W-1:0]     exp_sr;
    logic [`ME_BIT_CNT_W-1:0] sq_cnt;
    logic                     r2_start_q;
    logic                     mm_start_q;

    // ------------------------------
    // handshake outputs
    // ------------------------------

    assign busy     = (state != ST_IDLE);
    assign load     = start && (state == ST_IDLE);
    assign r2_start = r2_start_q;
    assign mm_start = mm_start_q;

    // product write happens in the done cycle of every multiply
    assign prod_wr  = mm_done;

    // last multiply takes result out of montgomery form
    assign valid    = mm_done && (state == ST_FROM_MONT);

    // opcode follows the state, so it stays put for the whole multiply
    always_comb begin
        case (state)
            ST_TO_MONT_ONE: mm_op = MM_R_ONE;
            ST_TO_MONT_X:   mm_op = MM_X_R;
            ST_SQUARE:      mm_op = MM_SQ;
            ST_MULT:        mm_op = MM_MUL;
            ST_FROM_MONT:   mm_op = MM_ONE;
            default:        mm_op = MM_R_ONE;
        endcase
    end

    // ------------------------------
    // sequencer
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            exp_sr     <= '0;
            sq_cnt     <= '0;
            r2_start_q <= 1'b0;
            mm_start_q <= 1'b0;
        end else begin
            // both starts are single cycle pulses
            r2_start_q <= 1'b0;
            mm_start_q <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (load) begin
                        exp_sr     <= y;
                        sq_cnt     <= '0;
                        r2_start_q <= 1'b1;
                        state      <= ST_R2;
                    end
                end

                // wait for rou = 2^(2W) mod m
                ST_R2: begin
                    if (r2_done) begin
                        mm_start_q <= 1'b1;
                        state      <= ST_TO_MONT_ONE;
                    end
                end

                // result = mont(rou, 1)
                ST_TO_MONT_ONE: begin
                    if (mm_done) begin
                        mm_start_q <= 1'b1;
                        state      <= ST_TO_MONT_X;
                    end
                end

                // result2 = mont(x, rou)
                ST_TO_MONT_X: begin
                    if (mm_done) begin
                        mm_start_q <= 1'b1;
                        state      <= ST_SQUARE;
                    end
                end

                // one square per exponent bit, msb first
                ST_SQUARE: begin
                    if (mm_done) begin
                        exp_sr     <= exp_sr << 1;
                        sq_cnt     <= sq_cnt + 1'b1;
                        mm_start_q <= 1'b1;
                        if (exp_sr[`ME_EXP_W-1]) begin
                            state <= ST_MULT;
                        end else if (sq_cnt == LAST_SQ) begin
                            state <= ST_FROM_MONT;
                        end else begin
                            state <= ST_SQUARE;
                        end
                    end
                end

                // bit was one, multiply by montgomery x
                ST_MULT: begin
                    if (mm_done) begin
                        mm_start_q <= 1'b1;
                        if (sq_cnt == ALL_SQ) begin
                            state <= ST_FROM_MONT;
                        end else begin
                            state <= ST_SQUARE;
                        end
                    end
                end

                // result = mont(result, 1), then done
                ST_FROM_MONT: begin
                    if (mm_done) begin
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/me_operands.sv */
`include "me_config.svh"

module me_operands
    import me_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  logic [`ME_WIDTH-1:0] x,
    input  logic [`ME_WIDTH-1:0] m,
    input  logic [`ME_WIDTH-1:0] rou,
    input  mm_op_t               mm_op,
    input  logic                 prod_wr,
    input  logic [`ME_WIDTH-1:0] product,
    output logic [`ME_WIDTH-1:0] m_q,
    output logic [`ME_WIDTH-1:0] mm_a,
    output logic [`ME_WIDTH-1:0] mm_b,
    output logic [`ME_WIDTH-1:0] result
);

    localparam logic [`ME_WIDTH-1:0] ONE = 1;

    logic [`ME_WIDTH-1:0] x_q;
    logic [`ME_WIDTH-1:0] result_q;
    logic [`ME_WIDTH-1:0] result2_q;

    // ------------------------------
    // operand select
    // ------------------------------

    // mm_a is the operand scanned bit by bit in the multiplier
    always_comb begin
        case (mm_op)
            MM_R_ONE: begin
                mm_a = rou;
                mm_b = ONE;
            end
            MM_X_R: begin
                mm_a = x_q;
                mm_b = rou;
            end
            MM_SQ: begin
                mm_a = result_q;
                mm_b = result_q;
            end
            MM_MUL: begin
                mm_a = result_q;
                mm_b = result2_q;
            end
            default: begin
                mm_a = result_q;
                mm_b = ONE;
            end
        endcase
    end

    // ------------------------------
    // operand registers
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_q       <= '0;
            x_q       <= '0;
            result_q  <= '0;
            result2_q <= '0;
        end else begin
            if (load) begin
                m_q <= m;
                x_q <= x;
            end
            // montgomery x goes to result2, everything else to result
            if (prod_wr) begin
                if (mm_op == MM_X_R) begin
                    result2_q <= product;
                end else begin
                    result_q <= product;
                end
            end
        end
    end

    // bypass so the final value is visible in the valid cycle
    assign result = prod_wr ? product : result_q;

endmodule

/* design/r2_gen.sv */
`include "me_config.svh"

module r2_gen (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [`ME_WIDTH-1:0] m,
    output logic                 done,
    output logic [`ME_WIDTH-1:0] rou
);

    // 2W doublings of 1 give 2^(2W) mod m
    localparam logic [`ME_BIT_CNT_W-1:0] LAST_STEP = 2 * `ME_WIDTH - 1;

    logic [`ME_WIDTH-1:0]     m_q;
    logic [`ME_ACC_W-1:0]     val;
    logic [`ME_ACC_W-1:0]     dbl;
    logic [`ME_BIT_CNT_W-1:0] step_cnt;
    logic                     running;

    assign dbl = {val[`ME_ACC_W-2:0], 1'b0};
    assign rou = val[`ME_WIDTH-1:0];

    // value stays below m after every step
    always_ff @(posedge clk) begin
        if (start) begin
            m_q <= m;
            val <= 1;
        end else if (running) begin
            val <= (dbl >= {2'b00, m_q}) ? dbl - {2'b00, m_q} : dbl;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running  <= 1'b1;
                step_cnt <= '0;
            end else if (running) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == LAST_STEP) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

endmodule

/* design/mont_mult.sv */
`include "me_config.svh"

module mont_mult (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [`ME_WIDTH-1:0] a,
    input  logic [`ME_WIDTH-1:0] b,
    input  logic [`ME_WIDTH-1:0] m,
    output logic                 done,
    output logic [`ME_WIDTH-1:0] product
);

    localparam logic [`ME_BIT_CNT_W-1:0] LAST_BIT = `ME_WIDTH - 1;

    logic [`ME_WIDTH-1:0]     a_sr;
    logic [`ME_WIDTH-1:0]     b_q;
    logic [`ME_WIDTH-1:0]     m_q;
    logic [`ME_ACC_W-1:0]     acc;
    logic [`ME_ACC_W-1:0]     sum_b;
    logic [`ME_ACC_W-1:0]     sum_m;
    logic [`ME_ACC_W-1:0]     acc_red;
    logic [`ME_BIT_CNT_W-1:0] bit_cnt;
    logic                     running;
    logic                     reduce;

    // one radix-2 step: add b if the a bit is set, make even with m
    always_comb begin
        sum_b = acc + (a_sr[0] ? {2'b00, b_q} : '0);
        sum_m = sum_b + (sum_b[0] ? {2'b00, m_q} : '0);
    end

    // acc stays below 2m, so a single subtraction reduces it
    assign acc_red = (acc >= {2'b00, m_q}) ? acc - {2'b00, m_q} : acc;

    // ------------------------------
    // datapath
    // ------------------------------

    always_ff @(posedge clk) begin
        if (start) begin
            a_sr <= a;
            b_q  <= b;
            m_q  <= m;
            acc  <= '0;
        end else if (running) begin
            a_sr <= a_sr >> 1;
            acc  <= sum_m >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (reduce) begin
            product <= acc_red[`ME_WIDTH-1:0];
        end
    end

    // ------------------------------
    // control
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            reduce  <= 1'b0;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done   <= reduce;
            reduce <= 1'b0;
            if (start) begin
                running <= 1'b1;
                bit_cnt <= '0;
            end else if (running) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == LAST_BIT) begin
                    running <= 1'b0;
                    reduce  <= 1'b1;
                end
            end
        end
    end

endmodule

/* design/me_pkg.sv */
`include "me_config.svh"

package me_pkg;

    // sequencer states, in the order they are visited
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_R2,
        ST_TO_MONT_ONE,
        ST_TO_MONT_X,
        ST_SQUARE,
        ST_MULT,
        ST_FROM_MONT
    } me_state_t;

    // multiply operations, operand pair and destination per opcode
    typedef enum logic [2:0] {
        MM_R_ONE,
        MM_X_R,
        MM_SQ,
        MM_MUL,
        MM_ONE
    } mm_op_t;

endpackage

/* design/me_config.svh */
`ifndef ME_CONFIG_SVH
`define ME_CONFIG_SVH

// operand, modulus and result width
`define ME_WIDTH 32

// exponent width, one square per exponent bit
`define ME_EXP_W `ME_WIDTH

// counters that run up to 2*W
`define ME_BIT_CNT_W 7

// montgomery and doubling accumulators need two guard bits
`define ME_ACC_W (`ME_WIDTH + 2)

`endif
